// ==== hw/globalRegBank.sv ====
// Eight global registers loaded or cleared by one-hot strobes, contents exposed as a flat word vector
`default_nettype none
`timescale 1ns/100ps

module globalRegBank
        import rfTypesPkg::*, windowLayoutPkg::*;
(
        input  logic                   Clk,
        input  logic                   rstN,
        input  globalStrobeT           globalStrobe,
        input  wordT                   writeData,
        output wordT [NumGlobals-1:0]  globalWords
);

        // ************************************************************
        // Register array
        // ************************************************************

        // Clear has priority over load on the same register
        always_ff @(posedge Clk)
        begin
                if (!rstN)
                begin
                        globalWords <= '0;
                end
                else
                begin
                        for (int i = 0; i < NumGlobals; i++)
                        begin
                                if (globalStrobe.clear[i])
                                        globalWords[i] <= '0;
                                else if (globalStrobe.load[i])
                                        globalWords[i] <= writeData;
                        end
                end
        end

endmodule

`default_nettype wire

// ==== hw/readPortMux.sv ====
// Combinational read port that maps a virtual address through the window pointer and picks the register
`default_nettype none
`timescale 1ns/100ps

module readPortMux
        import rfTypesPkg::*, windowLayoutPkg::*;
(
        input  regAddrT                readAddr,
        input  cwpT                    cwp,
        input  wordT [NumGlobals-1:0]  globalWords,
        input  wordT [RingSize-1:0]    ringWords,
        output wordT                   readData
);

        // ************************************************************
        // Address mapping
        // ************************************************************
        logic     isGlobal;
        ringSlotT ringSlot;

        // Globals are shared by every window
        assign isGlobal = readAddr < regAddrT'(NumGlobals);

        // Only meaningful for addresses 8 and up
        assign ringSlot = physSlot(readAddr, cwp);

        // ************************************************************
        // Word select
        // ************************************************************
        always_comb
        begin
                if (isGlobal)
                        readData = globalWords[readAddr[$clog2(NumGlobals)-1:0]];
                else
                        readData = ringWords[ringSlot];
        end

endmodule

`default_nettype wire

// ==== hw/regWindowFile.sv ====
// Top level of the windowed register file joining write control, both banks and the two read ports
`default_nettype none
`timescale 1ns/100ps

module regWindowFile
        import rfTypesPkg::*, windowLayoutPkg::*;
(
        input  logic       Clk,
        input  logic       rstN,
        input  rfWriteCmdT writeCmd,
        input  cwpT        cwp,
        input  logic       windowEn,
        input  regAddrT    readAddrA,
        input  regAddrT    readAddrB,
        output wordT       readDataA,
        output wordT       readDataB
);

        globalStrobeT           globalStrobe;
        ringStrobeT             ringStrobe;
        wordT [NumGlobals-1:0]  globalWords;
        wordT [RingSize-1:0]    ringWords;

        // ************************************************************
        // Write side
        // ************************************************************
        windowCtrl ctrl (
                .writeCmd     (writeCmd),
                .cwp          (cwp),
                .windowEn     (windowEn),
                .globalStrobe (globalStrobe),
                .ringStrobe   (ringStrobe)
        );

        globalRegBank globalBank (
                .Clk          (Clk),
                .rstN         (rstN),
                .globalStrobe (globalStrobe),
                .writeData    (writeCmd.data),
                .globalWords  (globalWords)
        );

        windowRegRing ringBank (
                .Clk        (Clk),
                .rstN       (rstN),
                .ringStrobe (ringStrobe),
                .writeData  (writeCmd.data),
                .ringWords  (ringWords)
        );

        // ************************************************************
        // Read ports
        // ************************************************************
        readPortMux readPortA (
                .readAddr    (readAddrA),
                .cwp         (cwp),
                .globalWords (globalWords),
                .ringWords   (ringWords),
                .readData    (readDataA)
        );

        readPortMux readPortB (
                .readAddr    (readAddrB),
                .cwp         (cwp),
                .globalWords (globalWords),
                .ringWords   (ringWords),
                .readData    (readDataB)
        );

endmodule

`default_nettype wire

// ==== hw/rfTypesPkg.sv ====
// Data, address and window pointer types plus the write command bundle shared by the register file
`default_nettype none

package rfTypesPkg;

        // ************************************************************
        // Widths
        // ************************************************************
        localparam int DataWidth = 32;
        localparam int AddrWidth = 5;
        localparam int CwpWidth  = 2;

        // One register value
        typedef logic [DataWidth-1:0] wordT;

        // Virtual register number as seen by software, 0 to 31
        typedef logic [AddrWidth-1:0] regAddrT;

        // Current window pointer
        typedef logic [CwpWidth-1:0] cwpT;

        // ************************************************************
        // Write side request, one per cycle
        // ************************************************************
        typedef struct packed {
                logic    loadEn;
                regAddrT loadSel;
                logic    clearEn;
                regAddrT clearSel;
                wordT    data;
        } rfWriteCmdT;

endpackage

`default_nettype wire

// ==== hw/windowCtrl.sv ====
// Turns load and clear requests into one-hot global and ring strobes under the current window pointer
`default_nettype none
`timescale 1ns/100ps

module windowCtrl
        import rfTypesPkg::*, windowLayoutPkg::*;
(
        input  rfWriteCmdT   writeCmd,
        input  cwpT          cwp,
        input  logic         windowEn,
        output globalStrobeT globalStrobe,
        output ringStrobeT   ringStrobe
);

        // ************************************************************
        // Decode helpers
        // ************************************************************

        // Globals ignore the window enable and the window pointer
        function automatic logic [NumGlobals-1:0] globalHit(logic en, regAddrT sel);
                logic [NumGlobals-1:0] hit;
                hit = '0;
                if (en && (sel < regAddrT'(NumGlobals)))
                begin
                        hit[sel[$clog2(NumGlobals)-1:0]] = 1'b1;
                end
                return hit;
        endfunction

        // Windowed selects map through the pointer and need the window enable
        function automatic logic [RingSize-1:0] ringHit(logic en, regAddrT sel,
                                                        cwpT winPtr, logic winEn);
                logic [RingSize-1:0] hit;
                hit = '0;
                if (en && winEn && (sel >= regAddrT'(NumGlobals)))
                begin
                        hit[physSlot(sel, winPtr)] = 1'b1;
                end
                return hit;
        endfunction

        // ************************************************************
        // Strobes
        // ************************************************************

        // Load and clear decode separately, both may fire in one cycle
        always_comb
        begin
                globalStrobe.load  = globalHit(writeCmd.loadEn, writeCmd.loadSel);
                globalStrobe.clear = globalHit(writeCmd.clearEn, writeCmd.clearSel);
        end

        always_comb
        begin
                ringStrobe.load  = ringHit(writeCmd.loadEn, writeCmd.loadSel, cwp, windowEn);
                ringStrobe.clear = ringHit(writeCmd.clearEn, writeCmd.clearSel, cwp, windowEn);
        end

endmodule

`default_nettype wire

// ==== hw/windowLayoutPkg.sv ====
// Window geometry, virtual to physical slot mapping and strobe bundles used by control, banks and read ports
`default_nettype none

package windowLayoutPkg;

        import rfTypesPkg::*;

        // ************************************************************
        // Geometry
        // ************************************************************
        localparam int NumGlobals   = 8;
        localparam int NumWindows   = 4;
        // Fresh registers per window (outs plus locals)
        localparam int WindowStride = 16;
        localparam int RingSize     = NumWindows * WindowStride;

        // Index into the ring of windowed registers
        typedef logic [$clog2(RingSize)-1:0] ringSlotT;

        // Ring slot for a windowed virtual register (8 to 31) in window cwp.
        // Wraps modulo the ring, so the ins of one window land on the outs of the next
        function automatic ringSlotT physSlot(regAddrT addr, cwpT cwp);
                ringSlotT base;
                ringSlotT offset;
                base   = ringSlotT'(cwp) * ringSlotT'(WindowStride);
                offset = ringSlotT'(addr) - ringSlotT'(NumGlobals);
                return base + offset;
        endfunction

        // ************************************************************
        // Per register strobes, one-hot or zero
        // ************************************************************
        typedef struct packed {
                logic [NumGlobals-1:0] load;
                logic [NumGlobals-1:0] clear;
        } globalStrobeT;

        typedef struct packed {
                logic [RingSize-1:0] load;
                logic [RingSize-1:0] clear;
        } ringStrobeT;

endpackage

`default_nettype wire

// ==== hw/windowRegRing.sv ====
// Ring of 64 windowed registers loaded or cleared by strobes that arrive already mapped to physical slots
`default_nettype none
`timescale 1ns/100ps

module windowRegRing
        import rfTypesPkg::*, windowLayoutPkg::*;
(
        input  logic                 Clk,
        input  logic                 rstN,
        input  ringStrobeT           ringStrobe,
        input  wordT                 writeData,
        output wordT [RingSize-1:0]  ringWords
);

        // ************************************************************
        // Ring storage
        // ************************************************************

        // No window logic here, the slot index is the physical register
        always_ff @(posedge Clk)
        begin
                if (!rstN)
                begin
                        ringWords <= '0;
                end
                else
                begin
                        for (int slot = 0; slot < RingSize; slot++)
                        begin
                                // Clear wins over a load to the same slot
                                if (ringStrobe.clear[slot])
                                        ringWords[slot] <= '0;
                                else if (ringStrobe.load[slot])
                                        ringWords[slot] <= writeData;
                        end
                end
        end

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the windowed register file testbench with Verilator and run it.
# The run passes only when the simulation prints the pass message.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/100ps \
        --top-module regWindowFile_tb -Mdir obj_dir -f src.f
buildStatus=$?
if [ $buildStatus -ne 0 ]; then
        echo "Verilator build failed with status $buildStatus"
        exit 1
fi

simOut=$(./obj_dir/VregWindowFile_tb)
simStatus=$?
printf '%s\n' "$simOut"
if [ $simStatus -ne 0 ]; then
        echo "Simulation exited with status $simStatus"
        exit 1
fi

if printf '%s\n' "$simOut" | grep -qx "=== PASS ==="; then
        exit 0
else
        echo "Pass message not found in simulation output"
        exit 1
fi

// ==== src.f ====
hw/rfTypesPkg.sv
hw/windowLayoutPkg.sv
hw/windowCtrl.sv
hw/globalRegBank.sv
hw/windowRegRing.sv
hw/readPortMux.sv
hw/regWindowFile.sv
testbench/regWindowFile_asserts.sv
testbench/regWindowFile_tb.sv

// ==== testbench/regWindowFile_asserts.sv ====
// Concurrent checks on the write strobes of windowCtrl, attached by bind from the testbench
`default_nettype none
`timescale 1ns/100ps

module regWindowFile_asserts
        import rfTypesPkg::*, windowLayoutPkg::*;
(
        input logic         Clk,
        input rfWriteCmdT   writeCmd,
        input logic         windowEn,
        input globalStrobeT globalStrobe,
        input ringStrobeT   ringStrobe
);

        // ************************************************************
        // One-hot strobes
        // ************************************************************
        globalLoadOneHot: assert property (@(posedge Clk) $onehot0(globalStrobe.load))
                else $error("global load strobe has more than one bit set");

        ringLoadOneHot: assert property (@(posedge Clk) $onehot0(ringStrobe.load))
                else $error("ring load strobe has more than one bit set");

        globalClearOneHot: assert property (@(posedge Clk) $onehot0(globalStrobe.clear))
                else $error("global clear strobe has more than one bit set");

        ringClearOneHot: assert property (@(posedge Clk) $onehot0(ringStrobe.clear))
                else $error("ring clear strobe has more than one bit set");

        // ************************************************************
        // Window gating
        // ************************************************************
        ringQuietWhenDisabled: assert property (@(posedge Clk)
                !windowEn |-> (ringStrobe == '0))
                else $error("ring strobe active while window enable is low");

        // Globals never reach the ring
        globalLoadNotInRing: assert property (@(posedge Clk)
                (writeCmd.loadSel < regAddrT'(NumGlobals)) |-> (ringStrobe.load == '0))
                else $error("global load select produced a ring load strobe");

        globalClearNotInRing: assert property (@(posedge Clk)
                (writeCmd.clearSel < regAddrT'(NumGlobals)) |-> (ringStrobe.clear == '0))
                else $error("global clear select produced a ring clear strobe");

endmodule

`default_nettype wire

// ==== testbench/regWindowFile_tb.sv ====
// Table driven testbench for the windowed register file, built and run from the project root via src.f
`default_nettype none
`timescale 1ns/100ps

module regWindowFile_tb
        import rfTypesPkg::*, windowLayoutPkg::*;
();

        localparam int ClkPeriod = 4;

        typedef struct packed {
                rfWriteCmdT cmd;
                cwpT        cwp;
                logic       winEn;
                regAddrT    addrA;
                regAddrT    addrB;
                wordT       expA;
                wordT       expB;
                logic [3:0] grp;
        } rowT;

        logic       Clk = 1'b0;
        logic       rstN;
        rfWriteCmdT writeCmd;
        cwpT        cwp;
        logic       windowEn;
        regAddrT    readAddrA;
        regAddrT    readAddrB;
        wordT       readDataA;
        wordT       readDataB;

        rowT         rows[$];
        wordT        globalModel[8];
        wordT        ringModel[64];
        logic [31:0] lfsrState = 32'h1fbe;
        logic        tableReady = 1'b0;
        int          errorCount = 0;
        int          checkCount = 0;
        string       groupNames[6] = '{"reset", "globals", "locals", "outs/ins overlap",
                                       "window enable", "clear and load"};

        regWindowFile dut (
                .Clk       (Clk),
                .rstN      (rstN),
                .writeCmd  (writeCmd),
                .cwp       (cwp),
                .windowEn  (windowEn),
                .readAddrA (readAddrA),
                .readAddrB (readAddrB),
                .readDataA (readDataA),
                .readDataB (readDataB)
        );

        bind windowCtrl regWindowFile_asserts ctrlAsserts (
                .Clk          (regWindowFile_tb.Clk),
                .writeCmd     (writeCmd),
                .windowEn     (windowEn),
                .globalStrobe (globalStrobe),
                .ringStrobe   (ringStrobe)
        );

        always #(ClkPeriod / 2) Clk = ~Clk;

        // ************************************************************
        // Random data and reference model
        // ************************************************************

        // Galois LFSR with taps for x^32 + x^22 + x^2 + x + 1
        function automatic logic lfsrBit();
                logic outBit;
                outBit = lfsrState[0];
                lfsrState = lfsrState >> 1;
                if (outBit)
                        lfsrState = lfsrState ^ 32'h80200003;
                return outBit;
        endfunction

        function automatic wordT nextWord();
                wordT w;
                w = '0;
                for (int i = 0; i < 32; i++)
                        w = {w[30:0], lfsrBit()};
                return w;
        endfunction

        // Each window adds 16 fresh registers on a ring of 64
        function automatic logic [5:0] ringIndex(regAddrT addr, cwpT winPtr);
                int s;
                s = (int'(winPtr) * 16 + int'(addr) - 8) % 64;
                return s[5:0];
        endfunction

        function automatic wordT readModel(regAddrT addr, cwpT winPtr);
                if (addr < 5'd8)
                        return globalModel[addr[2:0]];
                return ringModel[ringIndex(addr, winPtr)];
        endfunction

        task automatic writeModel(regAddrT addr, cwpT winPtr, logic winEn, wordT value);
                if (addr < 5'd8)
                        globalModel[addr[2:0]] = value;
                else if (winEn)
                        ringModel[ringIndex(addr, winPtr)] = value;
        endtask

        // ************************************************************
        // Table construction
        // ************************************************************

        // Expected reads see the state before this row's write lands
        task automatic addRow(int grp, bit ld, int ldSel, bit cl, int clSel,
                              int winPtr, bit winEn, int addrA, int addrB);
                rowT r;
                r.cmd.loadEn   = ld;
                r.cmd.loadSel  = regAddrT'(ldSel);
                r.cmd.clearEn  = cl;
                r.cmd.clearSel = regAddrT'(clSel);
                r.cmd.data     = nextWord();
                r.cwp          = cwpT'(winPtr);
                r.winEn        = winEn;
                r.addrA        = regAddrT'(addrA);
                r.addrB        = regAddrT'(addrB);
                r.expA         = readModel(r.addrA, r.cwp);
                r.expB         = readModel(r.addrB, r.cwp);
                r.grp          = grp[3:0];
                rows.push_back(r);
                // Load first so that a clear on the same register wins
                if (ld)
                        writeModel(r.cmd.loadSel, r.cwp, winEn, r.cmd.data);
                if (cl)
                        writeModel(r.cmd.clearSel, r.cwp, winEn, '0);
        endtask

        task automatic readRow(int grp, int winPtr, bit winEn, int addrA, int addrB);
                addRow(grp, 1'b0, 0, 1'b0, 0, winPtr, winEn, addrA, addrB);
        endtask

        task automatic loadRow(int grp, int winPtr, bit winEn, int sel, int addrA, int addrB);
                addRow(grp, 1'b1, sel, 1'b0, 0, winPtr, winEn, addrA, addrB);
        endtask

        task automatic buildTable();
                int outReg;
                for (int i = 0; i < 8; i++)
                        globalModel[i] = '0;
                for (int i = 0; i < 64; i++)
                        ringModel[i] = '0;
                for (int w = 0; w < 4; w++)
                        for (int a = 0; a < 32; a += 2)
                                readRow(0, w, 1'b1, a, a + 1);
                // Globals read on both ports in every window
                for (int g = 0; g < 8; g++)
                        loadRow(1, g % 4, 1'b1, g, 0, 1);
                for (int w = 0; w < 4; w++)
                        for (int g = 0; g < 8; g += 2)
                                readRow(1, w, 1'b1, (w % 2 == 0) ? g : g + 1,
                                        (w % 2 == 0) ? g + 1 : g);
                // Same local number in every window
                for (int w = 0; w < 4; w++)
                        loadRow(2, w, 1'b1, 20, 16, 23);
                for (int w = 0; w < 4; w++)
                        loadRow(2, w, 1'b1, 17, 20, 21);
                for (int w = 0; w < 4; w++)
                        readRow(2, w, 1'b1, 20, 17);
                // Outs of window w are the ins of window w - 1 on the wrapping ring
                for (int w = 0; w < 4; w++)
                        loadRow(3, w, 1'b1, 8 + (w * 3) % 8, 8, 24);
                for (int w = 0; w < 4; w++)
                begin
                        outReg = 8 + (w * 3) % 8;
                        readRow(3, w, 1'b1, outReg, 8);
                        readRow(3, (w + 3) % 4, 1'b1, outReg + 16, 24);
                end
                // Window enable low blocks only the ring
                addRow(4, 1'b1, 5, 1'b1, 20, 2, 1'b0, 5, 20);
                addRow(4, 1'b1, 12, 1'b1, 17, 1, 1'b0, 12, 17);
                loadRow(4, 0, 1'b0, 27, 27, 5);
                readRow(4, 2, 1'b0, 5, 20);
                readRow(4, 1, 1'b0, 12, 17);
                readRow(4, 0, 1'b0, 27, 5);
                // Clear priority and independent load and clear
                loadRow(5, 3, 1'b1, 10, 9, 10);
                addRow(5, 1'b1, 10, 1'b1, 10, 3, 1'b1, 10, 9);
                addRow(5, 1'b1, 2, 1'b1, 2, 0, 1'b1, 10, 11);
                addRow(5, 1'b1, 22, 1'b1, 3, 1, 1'b1, 2, 3);
                readRow(5, 3, 1'b1, 10, 9);
                readRow(5, 1, 1'b1, 22, 3);
                readRow(5, 1, 1'b1, 4, 21);
        endtask

        // ************************************************************
        // Checks and stimulus
        // ************************************************************
        task automatic checkWord(wordT got, wordT exp, int rowIdx, string port);
                checkCount++;
                if (got !== exp)
                begin
                        $display("ERR %0t ns: row %0d port %s read %h, expected %h",
                                 $time, rowIdx, port, got, exp);
                        errorCount++;
                end
        endtask

        task automatic driveRow(rowT r);
                writeCmd  = r.cmd;
                cwp       = r.cwp;
                windowEn  = r.winEn;
                readAddrA = r.addrA;
                readAddrB = r.addrB;
        endtask

        initial
        begin
                int groupRows;
                int groupErrs;
                int errsBefore;
                rstN      = 1'b0;
                writeCmd  = '0;
                cwp       = '0;
                windowEn  = 1'b0;
                readAddrA = '0;
                readAddrB = '0;
                groupRows = 0;
                groupErrs = 0;
                buildTable();
                tableReady = 1'b1;
                // Loads offered during reset must not land in either bank
                windowEn = 1'b1;
                for (int k = 0; k < 5; k++)
                begin
                        writeCmd.loadEn  = 1'b1;
                        writeCmd.loadSel = regAddrT'(k * 6 + 3);
                        writeCmd.data    = nextWord();
                        cwp              = cwpT'(k);
                        @(posedge Clk);
                        #1;
                end
                rstN     = 1'b1;
                writeCmd = '0;
                cwp      = '0;
                windowEn = 1'b0;
                for (int i = 0; i < rows.size(); i++)
                begin
                        @(posedge Clk);
                        #1 driveRow(rows[i]);
                        // Sample just before the next edge
                        #2.5;
                        errsBefore = errorCount;
                        checkWord(readDataA, rows[i].expA, i, "A");
                        checkWord(readDataB, rows[i].expB, i, "B");
                        groupRows++;
                        groupErrs += errorCount - errsBefore;
                        if (i == rows.size() - 1 || rows[i + 1].grp != rows[i].grp)
                        begin
                                $display("test %0d (%s): %0d rows, %0d errors",
                                         rows[i].grp, groupNames[rows[i].grp],
                                         groupRows, groupErrs);
                                groupRows = 0;
                                groupErrs = 0;
                        end
                end
                $display("summary: %0d rows, %0d checks, %0d errors",
                         rows.size(), checkCount, errorCount);
                if (errorCount == 0)
                        $display("=== PASS ===");
                else
                        $display("=== FAIL ===");
                $finish;
        end

        // Watchdog sized from the table plus margin for reset
        initial
        begin
                wait (tableReady);
                #((rows.size() + 20) * ClkPeriod);
                $display("Timeout: the table did not finish in the expected time");
                $display("=== FAIL ===");
                $finish;
        end

endmodule

`default_nettype wire
